// File: wisc16.f
+incdir+verilog
verilog/wisc16Pkg.sv
verilog/progCounter.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/alu.sv
verilog/wordMem.sv
verilog/wisc16Core.sv
dv/wisc16_assert.sv
dv/wisc16Tb.sv

// File: dv/wisc16Tb.sv
// Directed tests with expected state from the ISA rules; data memory is never reset between tests
`default_nettype none
`timescale 1ns/10ps

module wisc16Tb;

   localparam int runTimeout = 300;   // Cycles allowed per program

   logic            clk;
   logic            rstN;
   logic            loadEn;
   wisc16Pkg::wordT loadAddr;
   wisc16Pkg::wordT loadData;
   wisc16Pkg::wordT dbgAddr;
   wisc16Pkg::wordT dbgData;
   wire             halt;
   wire             err;

   wisc16Pkg::wordT prog[$];
   logic [31:0]     lfsr = 32'h02a0e1f1;
   int              errorCount = 0;
   int              checkCount = 0;
   int              errCycles;

   wisc16Core dut0 (
      .clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .dbgAddr(dbgAddr), .dbgData(dbgData), .halt(halt), .err(err)
   );

   bind progCounter wisc16Assert pcChk0 (
      .clk(clk), .rstN(rstN), .pc(pc), .isHalted(runState == wisc16Pkg::halted),
      .trap(trap), .regWrite(1'b0), .memWrite(1'b0), .halt(halt), .err(1'b0)
   );
   bind instrDecode wisc16Assert decChk0 (
      .clk(wisc16Tb.clk), .rstN(wisc16Tb.rstN), .pc('0), .isHalted(1'b0),
      .trap(trap), .regWrite(regWrite), .memWrite(memWrite), .halt(halt), .err(err)
   );

   always #50 clk = ~clk;

   // Galois LFSR, one step per bit
   function automatic logic [15:0] takeBits(int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic wisc16Pkg::wordT sext8(logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic wisc16Pkg::wordT sext5(logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   // Instruction encoders
   function automatic wisc16Pkg::wordT rTypeWord(logic [2:0] rs, logic [2:0] rt, logic [2:0] rd,
                                                 logic [1:0] funct);
      return {wisc16Pkg::opRType, rs, rt, rd, funct};
   endfunction

   function automatic wisc16Pkg::wordT iTypeWord(wisc16Pkg::opCodeT op, logic [2:0] rs,
                                                 logic [2:0] rt, logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic wisc16Pkg::wordT lbiWord(logic [2:0] rs, logic [7:0] imm);
      return {wisc16Pkg::opLbi, rs, imm};
   endfunction

   function automatic wisc16Pkg::wordT beqzWord(logic [2:0] rs, logic [7:0] disp);
      return {wisc16Pkg::opBeqz, rs, disp};
   endfunction

   function automatic wisc16Pkg::wordT jumpWord(logic [10:0] disp);
      return {wisc16Pkg::opJ, disp};
   endfunction

   function automatic wisc16Pkg::wordT bareWord(wisc16Pkg::opCodeT op);
      return {op, 11'b0};
   endfunction

   task automatic compareVal(wisc16Pkg::wordT got, wisc16Pkg::wordT exp, string what);
      checkCount++;
      if (got !== exp) begin
         $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
         errorCount++;
      end
   endtask

   // Loads prog under reset, then runs until HALT
   task automatic loadAndRun();
      int   cyc;
      logic done;
      @(posedge clk);
      #5;
      rstN = 1'b0;
      cyc  = 0;
      foreach (prog[i]) begin
         loadEn   = 1'b1;
         loadAddr = wisc16Pkg::wordT'(2 * i);
         loadData = prog[i];
         @(posedge clk);
         #5;
         cyc++;
      end
      loadEn = 1'b0;
      while (cyc < 10) begin
         @(posedge clk);
         #5;
         cyc++;
      end
      rstN      = 1'b1;
      errCycles = 0;
      done      = 1'b0;
      cyc       = 0;
      while (!done && cyc < runTimeout) begin
         @(negedge clk);   // Mid-cycle, decode outputs settled
         if (err) errCycles++;
         if (halt) done = 1'b1;
         cyc++;
      end
      if (!done) begin
         $display("timeout: the core did not reach HALT within %0d cycles", runTimeout);
         errorCount++;
      end
   endtask

   task automatic checkWord(wisc16Pkg::wordT addr, wisc16Pkg::wordT exp, string what);
      @(posedge clk);
      #5;
      dbgAddr = addr;
      @(negedge clk);
      compareVal(dbgData, exp, what);
   endtask

   task automatic arithTest();
      logic [7:0] a;
      logic [7:0] b;
      logic [4:0] k;
      a = 8'(takeBits(8));
      b = 8'(takeBits(8));
      k = 5'(takeBits(5));
      prog.delete();
      prog.push_back(lbiWord(1, a));
      prog.push_back(lbiWord(2, b));
      prog.push_back(rTypeWord(1, 2, 3, 2'b00));   // ADD
      prog.push_back(rTypeWord(1, 2, 4, 2'b01));   // SUB
      prog.push_back(rTypeWord(1, 2, 5, 2'b10));   // AND
      prog.push_back(rTypeWord(1, 2, 6, 2'b11));   // OR
      prog.push_back(iTypeWord(wisc16Pkg::opAddi, 1, 7, k));
      prog.push_back(lbiWord(0, 8'd64));
      for (int r = 3; r < 8; r++) begin
         prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, r, 5'(2 * (r - 3))));
      end
      prog.push_back(bareWord(wisc16Pkg::opHalt));
      loadAndRun();
      checkWord(64, sext8(a) + sext8(b), "ADD");
      checkWord(66, sext8(a) - sext8(b), "SUB");
      checkWord(68, sext8(a) & sext8(b), "AND");
      checkWord(70, sext8(a) | sext8(b), "OR");
      checkWord(72, sext8(a) + sext5(k), "ADDI");
      compareVal(16'(errCycles), 16'd0, "err cycles in arithmetic");
   endtask

   task automatic memoryTest();
      logic [7:0] v [3];
      prog.delete();
      prog.push_back(lbiWord(0, 8'd100));
      for (int i = 0; i < 3; i++) begin
         v[i] = 8'(takeBits(8));
         prog.push_back(lbiWord(1, v[i]));
         prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'(4 * i)));
         prog.push_back(iTypeWord(wisc16Pkg::opLd, 0, 2, 5'(4 * i)));
         prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 2, 5'(10 + 2 * i)));   // Uses fresh r2
      end
      prog.push_back(bareWord(wisc16Pkg::opHalt));
      loadAndRun();
      for (int i = 0; i < 3; i++) begin
         checkWord(wisc16Pkg::wordT'(100 + 4 * i), sext8(v[i]), "stored word");
         checkWord(wisc16Pkg::wordT'(110 + 2 * i), sext8(v[i]), "loaded copy");
      end
   endtask

   task automatic controlTest();
      prog.delete();
      prog.push_back(lbiWord(0, 8'd120));
      prog.push_back(lbiWord(1, 8'd0));
      prog.push_back(lbiWord(2, 8'd5));
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'd0));   // Clear markers
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'd4));
      prog.push_back(beqzWord(1, 8'd2));                        // Taken
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 2, 5'd0));
      prog.push_back(beqzWord(2, 8'd2));                        // Falls through
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 2, 5'd2));
      prog.push_back(jumpWord(11'd2));
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 2, 5'd4));
      prog.push_back(bareWord(wisc16Pkg::opHalt));
      loadAndRun();
      checkWord(120, 16'd0, "marker after taken BEQZ");
      checkWord(122, 16'd5, "store after untaken BEQZ");
      checkWord(124, 16'd0, "marker after J");
   endtask

   task automatic trapTest();
      prog.delete();
      prog.push_back(jumpWord(11'd4));                          // Over the handler
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 3, 5'd0));   // Handler at 2
      prog.push_back(bareWord(wisc16Pkg::opRti));
      prog.push_back(lbiWord(0, 8'd40));
      prog.push_back(lbiWord(3, 8'h5a));
      prog.push_back(lbiWord(1, 8'd0));
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'd0));
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'd2));
      prog.push_back(16'hf800);                                 // Illegal opcode
      prog.push_back(lbiWord(4, 8'd33));
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 4, 5'd2));
      prog.push_back(bareWord(wisc16Pkg::opHalt));
      loadAndRun();
      checkWord(40, 16'h005a, "handler marker");
      checkWord(42, 16'd33, "resumed store");
      compareVal(16'(errCycles), 16'd1, "err cycles in trap");
   endtask

   task automatic misalignedTest();
      prog.delete();
      prog.push_back(lbiWord(0, 8'd20));
      prog.push_back(lbiWord(1, 8'h11));
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'd0));
      prog.push_back(lbiWord(2, 8'h22));
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 2, 5'd1));   // Odd address
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 2, 5'd4));   // Word under the odd load
      prog.push_back(iTypeWord(wisc16Pkg::opLd, 0, 1, 5'd5));   // Must not write r1
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'd2));
      prog.push_back(bareWord(wisc16Pkg::opHalt));
      loadAndRun();
      checkWord(20, 16'h0011, "word after odd store");
      checkWord(22, 16'h0011, "r1 after odd load");
      compareVal(16'(errCycles), 16'd2, "err cycles in misaligned");
   endtask

   task automatic haltTest();
      int lowCycles;
      prog.delete();
      prog.push_back(lbiWord(0, 8'd30));
      prog.push_back(lbiWord(1, 8'd7));
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'd0));
      prog.push_back(bareWord(wisc16Pkg::opHalt));
      prog.push_back(lbiWord(1, 8'd9));                         // Never runs
      prog.push_back(iTypeWord(wisc16Pkg::opSt, 0, 1, 5'd0));
      loadAndRun();
      lowCycles = 0;
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         if (!halt) lowCycles++;
      end
      compareVal(16'(lowCycles), 16'd0, "cycles with halt low");
      checkWord(30, 16'd7, "word after halt");
   endtask

   initial begin
      clk      = 1'b0;
      rstN     = 1'b0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      dbgAddr  = '0;
      arithTest();
      memoryTest();
      controlTest();
      trapTest();
      misalignedTest();
      haltTest();
      $display("%0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/wisc16_assert.sv
// Checks assume no program starts with HALT or an illegal word; tie unused inputs low when bound
`default_nettype none
`timescale 1ns/10ps

module wisc16Assert (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire  wisc16Pkg::wordT  pc,
   input  wire                    isHalted,
   input  wire                    trap,
   input  wire                    regWrite,
   input  wire                    memWrite,
   input  wire                    halt,
   input  wire                    err
);

   // First running cycle after reset is quiet
   property quietAfterReset;
      @(posedge clk) (!$past(rstN) && rstN) |-> (!halt && !err);
   endproperty

   property pcHoldsWhenHalted;
      @(posedge clk) disable iff (!rstN) isHalted |=> (pc == $past(pc));
   endproperty

   property trapWritesNothing;
      @(posedge clk) disable iff (!rstN) trap |-> (!regWrite && !memWrite);
   endproperty

   quietAfterResetA: assert property (quietAfterReset) else $error("halt or err after reset");
   pcHoldA: assert property (pcHoldsWhenHalted) else $error("PC moved while halted");
   trapWriteA: assert property (trapWritesNothing) else $error("trap with a write enable");

endmodule

`default_nettype wire

// File: verilog/wisc16Core.sv
// Single-cycle wisc16; load the program only while rstN is low, no writes retire during reset
`default_nettype none
`timescale 1ns/10ps

module wisc16Core (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire                    loadEn,
   input  wire  wisc16Pkg::wordT  loadAddr,
   input  wire  wisc16Pkg::wordT  loadData,
   input  wire  wisc16Pkg::wordT  dbgAddr,
   output wisc16Pkg::wordT        dbgData,
   output wire                    halt,
   output wire                    err
);

   wisc16Pkg::wordT   pc;
   wisc16Pkg::wordT   instr;
   wisc16Pkg::wordT   immDisp;
   wisc16Pkg::wordT   readData1;
   wisc16Pkg::wordT   readData2;
   wisc16Pkg::wordT   aluResult;
   wisc16Pkg::wordT   memData;
   wisc16Pkg::wordT   writeData;
   wisc16Pkg::regSelT writeSel;
   wisc16Pkg::aluOpT  aluOp;
   logic              regWrite;
   logic              memWrite;
   logic              memToReg;
   logic              useImm;
   logic              immSel;
   logic              dstSel;
   logic              jump;
   logic              branch;
   logic              trap;
   logic              rti;
   logic              aIsZero;

   // Rd for R-format, Rs for LBI (its 8-bit immediate covers Rt), else Rt
   assign writeSel = dstSel ? instr[4:2] : (immSel ? instr[10:8] : instr[7:5]);

   assign writeData = memToReg ? memData : aluResult;

   progCounter pc0 (
      .clk         (clk),
      .rstN        (rstN),
      .jump        (jump),
      .branch      (branch),
      .branchTaken (aIsZero),
      .trap        (trap),
      .rti         (rti),
      .halt        (halt),
      .immDisp     (immDisp),
      .pc          (pc),
      .pcPlus2     ()
   );

   // Boot-load port is the only writer; second read port is left idle
   wordMem instrMem (
      .clk       (clk),
      .writeEn   (loadEn),
      .writeAddr (loadAddr),
      .writeData (loadData),
      .readAddr0 (pc),
      .readAddr1 ('0),
      .readData0 (instr),
      .readData1 ()
   );

   instrDecode decode0 (
      .opCode   (wisc16Pkg::opCodeT'(instr[15:11])),
      .funct    (instr[1:0]),
      .addrLsb  (aluResult[0]),
      .running  (rstN),   // Quiet while the program is loaded
      .regWrite (regWrite),
      .memWrite (memWrite),
      .memToReg (memToReg),
      .aluOp    (aluOp),
      .useImm   (useImm),
      .immSel   (immSel),
      .dstSel   (dstSel),
      .jump     (jump),
      .branch   (branch),
      .trap     (trap),
      .rti      (rti),
      .halt     (halt),
      .err      (err)
   );

   regFile rf0 (
      .clk       (clk),
      .rstN      (rstN),
      .readSel1  (instr[10:8]),
      .readSel2  (instr[7:5]),
      .writeSel  (writeSel),
      .writeData (writeData),
      .writeEn   (regWrite),
      .readData1 (readData1),
      .readData2 (readData2)
   );

   alu alu0 (
      .aluOp    (aluOp),
      .useImm   (useImm),
      .immSel   (immSel),
      .a        (readData1),
      .b        (readData2),
      .immField (instr[10:0]),
      .result   (aluResult),
      .immDisp  (immDisp),
      .aIsZero  (aIsZero)
   );

   // Port 1 serves the debug reads
   wordMem dataMem (
      .clk       (clk),
      .writeEn   (memWrite),
      .writeAddr (aluResult),
      .writeData (readData2),
      .readAddr0 (aluResult),
      .readAddr1 (dbgAddr),
      .readData0 (memData),
      .readData1 (dbgData)
   );

endmodule

`default_nettype wire

// File: verilog/wordMem.sv
// Word RAM on byte addresses; bit 0 is ignored, upper bits wrap, contents start unknown
`default_nettype none
`timescale 1ns/10ps

`include "wisc16_cfg.svh"

module wordMem (
   input  wire                    clk,
   input  wire                    writeEn,
   input  wire  wisc16Pkg::wordT  writeAddr,
   input  wire  wisc16Pkg::wordT  writeData,
   input  wire  wisc16Pkg::wordT  readAddr0,
   input  wire  wisc16Pkg::wordT  readAddr1,
   output wisc16Pkg::wordT        readData0,
   output wisc16Pkg::wordT        readData1
);

   localparam int idxW = $clog2(`WISC_MEM_DEPTH);

   wisc16Pkg::wordT mem [`WISC_MEM_DEPTH];

   // Reads see a write only after its edge
   assign readData0 = mem[readAddr0[idxW:1]];
   assign readData1 = mem[readAddr1[idxW:1]];

   always_ff @(posedge clk) begin
      if (writeEn) begin
         mem[writeAddr[idxW:1]] <= writeData;
      end
   end

endmodule

`default_nettype wire

// File: verilog/alu.sv
// Two's complement ALU with no carry or overflow flags; immField is instruction bits 10:0
`default_nettype none
`timescale 1ns/10ps

module alu (
   input  wire  wisc16Pkg::aluOpT  aluOp,
   input  wire                     useImm,
   input  wire                     immSel,
   input  wire  wisc16Pkg::wordT   a,
   input  wire  wisc16Pkg::wordT   b,
   input  wire  [10:0]             immField,
   output wisc16Pkg::wordT         result,
   output wisc16Pkg::wordT         immDisp,
   output logic                    aIsZero
);

   wisc16Pkg::wordT imm;
   wisc16Pkg::wordT opB;

   // Operand immediate, 8 bits for LBI, else 5 bits
   assign imm = immSel ? wisc16Pkg::wordT'($signed(immField[7:0]))
                       : wisc16Pkg::wordT'($signed(immField[4:0]));

   // Branch offset, 11 bits for J, 8 bits for BEQZ
   assign immDisp = immSel ? wisc16Pkg::wordT'($signed(immField))
                           : wisc16Pkg::wordT'($signed(immField[7:0]));

   assign opB = useImm ? imm : b;

   always_comb begin
      case (aluOp)
         wisc16Pkg::aluAdd:     result = a + opB;   // Also load and store address
         wisc16Pkg::aluSub:     result = a - opB;   // Rs minus Rt
         wisc16Pkg::aluAnd:     result = a & opB;
         wisc16Pkg::aluOr:      result = a | opB;
         wisc16Pkg::aluPassImm: result = imm;
         wisc16Pkg::aluPassB:   result = b;
         default:               result = '0;
      endcase
   end

   // BEQZ tests Rs, which always arrives on a
   assign aIsZero = (a == '0);

endmodule

`default_nettype wire

// File: verilog/regFile.sv
// Eight registers all cleared on reset, none hardwired to zero; writes retire one cycle late
`default_nettype none
`timescale 1ns/10ps

`include "wisc16_cfg.svh"

module regFile (
   input  wire                      clk,
   input  wire                      rstN,
   input  wire  wisc16Pkg::regSelT  readSel1,
   input  wire  wisc16Pkg::regSelT  readSel2,
   input  wire  wisc16Pkg::regSelT  writeSel,
   input  wire  wisc16Pkg::wordT    writeData,
   input  wire                      writeEn,
   output wisc16Pkg::wordT          readData1,
   output wisc16Pkg::wordT          readData2
);

   wisc16Pkg::wordT   regs [`WISC_REG_COUNT];
   wisc16Pkg::regSelT pendSel;     // Posted write, retired into the array next edge
   wisc16Pkg::wordT   pendData;
   logic              pendValid;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `WISC_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
         pendValid <= 1'b0;
         pendSel   <= '0;
         pendData  <= '0;
      end else begin
         if (pendValid) begin
            regs[pendSel] <= pendData;
         end
         pendValid <= writeEn;
         pendSel   <= writeSel;
         pendData  <= writeData;
      end
   end

   // Posted write is the newest copy, so it wins over the array
   assign readData1 = (pendValid && readSel1 == pendSel) ? pendData : regs[readSel1];
   assign readData2 = (pendValid && readSel2 == pendSel) ? pendData : regs[readSel2];

endmodule

`default_nettype wire

// File: verilog/instrDecode.sv
// Purely combinational decode; addrLsb must come from the ALU address of the same instruction
`default_nettype none
`timescale 1ns/10ps

module instrDecode (
   input  wire  wisc16Pkg::opCodeT  opCode,
   input  wire  [1:0]               funct,
   input  wire                      addrLsb,
   input  wire                      running,
   output logic                     regWrite,
   output logic                     memWrite,
   output logic                     memToReg,
   output wisc16Pkg::aluOpT         aluOp,
   output logic                     useImm,
   output logic                     immSel,
   output logic                     dstSel,
   output logic                     jump,
   output logic                     branch,
   output logic                     trap,
   output logic                     rti,
   output logic                     halt,
   output logic                     err
);

   always_comb begin
      regWrite = 1'b0;
      memWrite = 1'b0;
      memToReg = 1'b0;
      aluOp    = wisc16Pkg::aluAdd;
      useImm   = 1'b0;
      immSel   = 1'b0;
      dstSel   = 1'b0;
      jump     = 1'b0;
      branch   = 1'b0;
      trap     = 1'b0;
      rti      = 1'b0;
      halt     = 1'b0;
      err      = 1'b0;

      case (opCode)
         wisc16Pkg::opHalt: begin
            halt = 1'b1;
         end
         wisc16Pkg::opNop: begin
            // No controls
         end
         wisc16Pkg::opRti: begin
            rti = 1'b1;
         end
         wisc16Pkg::opJ: begin
            jump   = 1'b1;
            immSel = 1'b1;   // 11-bit displacement
         end
         wisc16Pkg::opAddi: begin
            regWrite = 1'b1;
            useImm   = 1'b1;
         end
         wisc16Pkg::opBeqz: begin
            branch = 1'b1;   // 8-bit displacement, Rs on the A side
         end
         wisc16Pkg::opSt: begin
            useImm   = 1'b1;
            memWrite = !addrLsb;
            err      = addrLsb;
         end
         wisc16Pkg::opLd: begin
            useImm   = 1'b1;
            memToReg = 1'b1;
            regWrite = !addrLsb;   // Odd load leaves Rt alone
            err      = addrLsb;
         end
         wisc16Pkg::opLbi: begin
            regWrite = 1'b1;
            aluOp    = wisc16Pkg::aluPassImm;
            immSel   = 1'b1;
         end
         wisc16Pkg::opRType: begin
            regWrite = 1'b1;
            dstSel   = 1'b1;
            case (funct)
               2'b00:   aluOp = wisc16Pkg::aluAdd;
               2'b01:   aluOp = wisc16Pkg::aluSub;
               2'b10:   aluOp = wisc16Pkg::aluAnd;
               default: aluOp = wisc16Pkg::aluOr;
            endcase
         end
         default: begin
            trap = 1'b1;   // Illegal opcode
            err  = 1'b1;
         end
      endcase

      // Nothing moves while the core is held
      if (!running) begin
         regWrite = 1'b0;
         memWrite = 1'b0;
         jump     = 1'b0;
         branch   = 1'b0;
         trap     = 1'b0;
         rti      = 1'b0;
         halt     = 1'b0;
         err      = 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/progCounter.sv
// PC steps by 2 bytes; trap vector fixed at address 2 and a trap inside the handler overwrites EPC
`default_nettype none
`timescale 1ns/10ps

module progCounter (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire                    jump,
   input  wire                    branch,
   input  wire                    branchTaken,
   input  wire                    trap,
   input  wire                    rti,
   input  wire                    halt,
   input  wire  wisc16Pkg::wordT  immDisp,
   output wisc16Pkg::wordT        pc,
   output wisc16Pkg::wordT        pcPlus2
);

   wisc16Pkg::wordT     pcReg;
   wisc16Pkg::wordT     epcReg;   // Return address for RTI
   wisc16Pkg::wordT     nextPc;
   wisc16Pkg::runStateT runState;

   assign pc      = pcReg;
   assign pcPlus2 = pcReg + wisc16Pkg::wordT'(2);

   always_comb begin
      if (runState == wisc16Pkg::halted) begin
         nextPc = pcReg;
      end else if (trap) begin
         nextPc = wisc16Pkg::wordT'(2);   // Handler entry
      end else if (rti) begin
         nextPc = epcReg;
      end else if (jump || (branch && branchTaken)) begin
         nextPc = pcPlus2 + immDisp;      // Displacement is from the next instruction
      end else if (halt) begin
         nextPc = pcReg;   // Park on the HALT word so decode keeps halt high
      end else begin
         nextPc = pcPlus2;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pcReg    <= '0;
         epcReg   <= '0;
         runState <= wisc16Pkg::running;
      end else begin
         pcReg <= nextPc;
         if (trap && runState == wisc16Pkg::running) begin
            epcReg <= pcPlus2;   // Resume after the offending word
         end
         if (halt) begin
            runState <= wisc16Pkg::halted;   // Left only through reset
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/wisc16Pkg.sv
// Shared wisc16 types; opcode values are fixed by the instruction encoding and must not move
`default_nettype none

`include "wisc16_cfg.svh"

package wisc16Pkg;

   typedef logic [`WISC_WORD_W-1:0] wordT;                // Data word or byte address
   typedef logic [$clog2(`WISC_REG_COUNT)-1:0] regSelT;   // Register index

   // Instruction bits 15:11, anything not listed traps
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opRti   = 5'b00011,
      opJ     = 5'b00100,
      opAddi  = 5'b01000,
      opBeqz  = 5'b01100,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opLbi   = 5'b11000,
      opRType = 5'b11011  // ADD, SUB, AND, OR by funct
   } opCodeT;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluPassImm,
      aluPassB
   } aluOpT;

   typedef enum logic {
      running,
      halted
   } runStateT;

endpackage

`default_nettype wire

// File: verilog/wisc16_cfg.svh
// Sizes for the wisc16 core; the ISA field layout assumes a 16-bit word and eight registers
`ifndef WISC16_CFG_SVH
`define WISC16_CFG_SVH

// Data path and byte address width
`define WISC_WORD_W 16

// General registers, power of two so the select field packs into 3 bits
`define WISC_REG_COUNT 8

// Words per memory, instruction and data alike
// Byte address bits above the depth wrap around
`define WISC_MEM_DEPTH 256

`endif
